// ==== source/memoryPkg.sv ====
package memoryPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Storage geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int dataWidth      = 32;
    localparam int fifoDepth      = 16;
    localparam int burstLength    = 16;
    localparam int layerAddrWidth = 4;

    // FIFO pointer and occupancy widths
    localparam int fifoAddrWidth  = $clog2(fifoDepth);
    localparam int fifoCountWidth = fifoAddrWidth + 1;

    // Source of readData, registered in the controller
    localparam logic [1:0] selNone   = 2'd0;
    localparam logic [1:0] selBias   = 2'd1;
    localparam logic [1:0] selWeight = 2'd2;
    localparam logic [1:0] selLayer  = 2'd3;

    // Request codes on loadState and readState, other values act as idle
    typedef enum logic [2:0] {
        reqIdle   = 3'b000,
        reqBias   = 3'b001,
        reqWeight = 3'b010,
        reqLayer  = 3'b100
    } requestCode;

    // Controller states
    typedef enum logic [2:0] {
        idleState       = 3'd0,
        loadBiasState   = 3'd1,
        loadWeightState = 3'd2,
        loadLayerState  = 3'd3,
        readBiasState   = 3'd4,
        readWeightState = 3'd5,
        readLayerState  = 3'd6
    } controllerState;

endpackage

// ==== source/paramFifo.sv ====
`timescale 1ns/10ps

module paramFifo (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            writeEnable,
    input  logic                            readEnable,
    input  logic [memoryPkg::dataWidth-1:0] writeData,
    output logic [memoryPkg::dataWidth-1:0] readData,
    output logic                            full,
    output logic                            empty
);
    import memoryPkg::*;

    logic [dataWidth-1:0]      storage [fifoDepth];
    logic [fifoAddrWidth-1:0]  writePtr;
    logic [fifoAddrWidth-1:0]  readPtr;
    logic [fifoCountWidth-1:0] count;
    logic                      pushOk;
    logic                      popOk;

    assign full  = (count == fifoCountWidth'(fifoDepth));
    assign empty = (count == '0);

    // Accesses that cannot complete are ignored
    assign pushOk = writeEnable && !full;
    assign popOk  = readEnable && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end else begin
            if (pushOk) begin
                writePtr <= writePtr + 1'b1;
            end
            if (popOk) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage and read register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pushOk) begin
            storage[writePtr] <= writeData;
        end
    end

    // Popped word is visible one cycle after the pop
    always_ff @(posedge clk) begin
        if (popOk) begin
            readData <= storage[readPtr];
        end
    end

    // Pointer wrap and count must agree
    occupancyBound: assert property (
        @(posedge clk) disable iff (reset)
        count <= fifoCountWidth'(fifoDepth)
    ) else $error("paramFifo occupancy above depth");

    pointerSpread: assert property (
        @(posedge clk) disable iff (reset)
        !full |-> (fifoAddrWidth'(writePtr - readPtr) == count[fifoAddrWidth-1:0])
    ) else $error("paramFifo pointers disagree with count");

endmodule

// ==== source/layerBuffer.sv ====
`timescale 1ns/10ps

module layerBuffer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 enable,
    input  logic                                 writeEnable,
    input  logic [memoryPkg::layerAddrWidth-1:0] address,
    input  logic [memoryPkg::dataWidth-1:0]      writeData,
    output logic [memoryPkg::dataWidth-1:0]      readData
);
    import memoryPkg::*;

    // One burst worth of layer words
    logic [dataWidth-1:0] storage [burstLength];

    logic doWrite;
    logic doRead;

    assign doWrite = enable && writeEnable;
    assign doRead  = enable && !writeEnable;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[address] <= writeData;
        end
    end

    // Registered read port is the only state cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            readData <= '0;
        end else if (doRead) begin
            readData <= storage[address];
        end
    end

endmodule

// ==== source/wordCounter.sv ====
`timescale 1ns/10ps

module wordCounter (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 counterClear,
    input  logic                                 counterStep,
    output logic [memoryPkg::layerAddrWidth-1:0] wordIndex,
    output logic                                 lastWord
);
    import memoryPkg::*;

    localparam logic [layerAddrWidth-1:0] finalIndex = layerAddrWidth'(burstLength - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Word index within the current burst
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || counterClear) begin
            wordIndex <= '0;
        end else if (counterStep) begin
            wordIndex <= wordIndex + 1'b1;
        end
    end

    assign lastWord = (wordIndex == finalIndex);

    // The controller stops stepping once the final word is reached
    noStepPastLast: assert property (
        @(posedge clk) disable iff (reset)
        (counterStep && !counterClear) |-> !lastWord
    ) else $error("wordCounter stepped past the last word");

endmodule

// ==== source/memoryController.sv ====
`timescale 1ns/10ps

module memoryController (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ena,
    input  memoryPkg::requestCode loadState,
    input  memoryPkg::requestCode readState,
    input  logic                  biasFull,
    input  logic                  biasEmpty,
    input  logic                  weightFull,
    input  logic                  weightEmpty,
    input  logic                  loadValid,
    input  logic                  lastWord,
    output logic                  biasRst,
    output logic                  biasWrEn,
    output logic                  biasRdEn,
    output logic                  weightRst,
    output logic                  weightWrEn,
    output logic                  weightRdEn,
    output logic                  layerEna,
    output logic                  layerWea,
    output logic                  layerRst,
    output logic                  counterClear,
    output logic                  counterStep,
    output logic                  loadDone,
    output logic                  readValid,
    output logic [1:0]            readSelect
);
    import memoryPkg::*;

    controllerState state;
    controllerState nextState;

    logic burstStart;
    logic inLoad;
    logic loadWrite;
    logic layerRead;
    logic burstStep;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            idleState: begin
                if (ena) begin
                    // Host loads win over controller reads
                    case (loadState)
                        reqBias:   nextState = loadBiasState;
                        reqWeight: nextState = loadWeightState;
                        reqLayer:  nextState = loadLayerState;
                        default: begin
                            case (readState)
                                reqBias:   nextState = readBiasState;
                                reqWeight: nextState = readWeightState;
                                reqLayer:  nextState = readLayerState;
                                default:   nextState = idleState;
                            endcase
                        end
                    endcase
                end
            end
            loadBiasState, loadWeightState, loadLayerState: begin
                if (loadWrite && lastWord) begin
                    nextState = idleState;
                end
            end
            readBiasState: begin
                if (biasEmpty) begin
                    nextState = idleState;
                end
            end
            readWeightState: begin
                if (weightEmpty) begin
                    nextState = idleState;
                end
            end
            readLayerState: begin
                if (layerRead && lastWord) begin
                    nextState = idleState;
                end
            end
            default: nextState = idleState;
        endcase
    end

    assign burstStart = (state == idleState) && (nextState != idleState);

    ////////////////////////////////////////////////////////////////////////////
    // Store strobes
    ////////////////////////////////////////////////////////////////////////////

    // First burst cycle is spent on flush and counter clear
    assign inLoad = (state == loadBiasState) || (state == loadWeightState)
                 || (state == loadLayerState);
    assign loadWrite = inLoad && loadValid && !counterClear;
    assign layerRead = (state == readLayerState) && !counterClear;
    assign burstStep = loadWrite || layerRead;

    assign biasWrEn   = loadWrite && (state == loadBiasState) && !biasFull;
    assign weightWrEn = loadWrite && (state == loadWeightState) && !weightFull;
    assign biasRdEn   = (state == readBiasState) && !biasEmpty && !counterClear;
    assign weightRdEn = (state == readWeightState) && !weightEmpty && !counterClear;

    assign layerWea = (state == loadLayerState);
    assign layerEna = (loadWrite && layerWea) || layerRead;

    assign counterStep = burstStep && !lastWord;

    ////////////////////////////////////////////////////////////////////////////
    // Registered state and pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idleState;
            counterClear <= 1'b0;
            biasRst      <= 1'b0;
            weightRst    <= 1'b0;
            layerRst     <= 1'b0;
            loadDone     <= 1'b0;
            readValid    <= 1'b0;
            readSelect   <= selNone;
        end else begin
            state        <= nextState;
            counterClear <= burstStart;
            biasRst      <= burstStart && (nextState == loadBiasState);
            weightRst    <= burstStart && (nextState == loadWeightState);
            layerRst     <= burstStart && ((nextState == loadLayerState)
                                        || (nextState == readLayerState));
            loadDone     <= loadWrite && lastWord;
            readValid    <= biasRdEn || weightRdEn || layerRead;
            if (biasRdEn) begin
                readSelect <= selBias;
            end else if (weightRdEn) begin
                readSelect <= selWeight;
            end else if (layerRead) begin
                readSelect <= selLayer;
            end else begin
                readSelect <= selNone;
            end
        end
    end

    biasNoCollision: assert property (
        @(posedge clk) disable iff (reset) !(biasWrEn && biasRdEn)
    ) else $error("bias FIFO written and read together");

    weightNoCollision: assert property (
        @(posedge clk) disable iff (reset) !(weightWrEn && weightRdEn)
    ) else $error("weight FIFO written and read together");

    loadDoneSingle: assert property (
        @(posedge clk) disable iff (reset) loadDone |=> !loadDone
    ) else $error("loadDone longer than one cycle");

endmodule

// ==== source/memorySubsystem.sv ====
`timescale 1ns/10ps

module memorySubsystem (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ena,
    input  memoryPkg::requestCode           loadState,
    input  memoryPkg::requestCode           readState,
    input  logic [memoryPkg::dataWidth-1:0] loadData,
    input  logic                            loadValid,
    output logic [memoryPkg::dataWidth-1:0] readData,
    output logic                            readValid,
    output logic                            loadDone,
    output logic [3:0]                      memoryState
);
    import memoryPkg::*;

    // Bias FIFO
    logic biasRst;
    logic biasWrEn;
    logic biasRdEn;
    logic biasFull;
    logic biasEmpty;
    logic [dataWidth-1:0] biasData;

    // Weight FIFO
    logic weightRst;
    logic weightWrEn;
    logic weightRdEn;
    logic weightFull;
    logic weightEmpty;
    logic [dataWidth-1:0] weightData;

    // Layer buffer and burst counter
    logic layerEna;
    logic layerWea;
    logic layerRst;
    logic [dataWidth-1:0] layerData;
    logic counterClear;
    logic counterStep;
    logic lastWord;
    logic [layerAddrWidth-1:0] wordIndex;
    logic [1:0] readSelect;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    memoryController controller (
        .clk(clk), .reset(reset), .ena(ena),
        .loadState(loadState), .readState(readState),
        .biasFull(biasFull), .biasEmpty(biasEmpty),
        .weightFull(weightFull), .weightEmpty(weightEmpty),
        .loadValid(loadValid), .lastWord(lastWord),
        .biasRst(biasRst), .biasWrEn(biasWrEn), .biasRdEn(biasRdEn),
        .weightRst(weightRst), .weightWrEn(weightWrEn), .weightRdEn(weightRdEn),
        .layerEna(layerEna), .layerWea(layerWea), .layerRst(layerRst),
        .counterClear(counterClear), .counterStep(counterStep),
        .loadDone(loadDone), .readValid(readValid), .readSelect(readSelect)
    );

    wordCounter counter (
        .clk(clk), .reset(reset),
        .counterClear(counterClear), .counterStep(counterStep),
        .wordIndex(wordIndex), .lastWord(lastWord)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stores
    ////////////////////////////////////////////////////////////////////////////

    paramFifo biasFifo (
        .clk(clk), .reset(reset), .flush(biasRst),
        .writeEnable(biasWrEn), .readEnable(biasRdEn), .writeData(loadData),
        .readData(biasData), .full(biasFull), .empty(biasEmpty)
    );

    paramFifo weightFifo (
        .clk(clk), .reset(reset), .flush(weightRst),
        .writeEnable(weightWrEn), .readEnable(weightRdEn), .writeData(loadData),
        .readData(weightData), .full(weightFull), .empty(weightEmpty)
    );

    layerBuffer layerStore (
        .clk(clk), .reset(layerRst), .enable(layerEna), .writeEnable(layerWea),
        .address(wordIndex), .writeData(loadData), .readData(layerData)
    );

    // Output word follows the source registered with readValid
    always_comb begin
        case (readSelect)
            selBias:   readData = biasData;
            selWeight: readData = weightData;
            selLayer:  readData = layerData;
            default:   readData = '0;
        endcase
    end

    assign memoryState = {biasFull, biasEmpty, weightFull, weightEmpty};

endmodule

// ==== testbench/memorySubsystemTb.sv ====
`timescale 1ns/10ps

module memorySubsystemTb;
    import memoryPkg::*;

    localparam int  waitLimit   = 200;
    localparam int  quietCycles = 40;
    localparam time wordSpacing = 8;

    logic                 clk;
    logic                 reset;
    logic                 ena;
    requestCode           loadState;
    requestCode           readState;
    logic [dataWidth-1:0] loadData;
    logic                 loadValid;
    logic [dataWidth-1:0] readData;
    logic                 readValid;
    logic                 loadDone;
    logic [3:0]           memoryState;

    int                   errorCount;
    int                   doneCount;
    logic [dataWidth-1:0] readWords [$];
    time                  readStamps [$];
    logic [31:0]          lfsrState;

    memorySubsystem DUT (
        .clk(clk), .reset(reset), .ena(ena),
        .loadState(loadState), .readState(readState),
        .loadData(loadData), .loadValid(loadValid),
        .readData(readData), .readValid(readValid),
        .loadDone(loadDone), .memoryState(memoryState)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (loadDone) begin
                doneCount++;
            end
            if (readValid) begin
                readWords.push_back(readData);
                readStamps.push_back($time);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] current);
        return {current[30:0], current[31] ^ current[21] ^ current[1] ^ current[0]};
    endfunction

    task automatic drawBit(output logic bitOut);
        lfsrState = lfsrStep(lfsrState);
        bitOut = lfsrState[0];
    endtask

    function automatic requestCode targetCode(input string name);
        if (name == "bias") begin
            return reqBias;
        end else if (name == "weight") begin
            return reqWeight;
        end else if (name == "layer") begin
            return reqLayer;
        end
        return reqIdle;
    endfunction

    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    // Code is held for one cycle and sampled by the DUT on the next edge
    task automatic issueRequest(input logic isLoad, input requestCode code);
        @(posedge clk);
        if (isLoad) begin
            loadState <= code;
        end else begin
            readState <= code;
        end
        @(posedge clk);
        loadState <= reqIdle;
        readState <= reqIdle;
    endtask

    task automatic loadBurst(input requestCode target, input logic [dataWidth-1:0] base);
        int index;
        int cycles;
        int doneBefore;
        logic gapA;
        logic gapB;
        doneBefore = doneCount;
        index = 0;
        cycles = 0;
        issueRequest(1'b1, target);
        // First accepted word lands two edges after the request edge
        while (index < burstLength && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
            drawBit(gapA);
            drawBit(gapB);
            if (gapA && gapB) begin
                loadValid <= 1'b0;
            end else begin
                loadValid <= 1'b1;
                loadData  <= base + dataWidth'(index);
                index++;
            end
        end
        @(posedge clk);
        loadValid <= 1'b0;
        cycles = 0;
        while (doneCount == doneBefore && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (doneCount == doneBefore) begin
            errorCount++;
            $display("Timed out at %0t waiting for loadDone after a load", $time);
        end
        // Room for a stray second pulse
        waitCycles(4);
        if (doneCount > doneBefore + 1) begin
            errorCount++;
            $display("Mismatch at %0t: loadDone pulses %0d expected 1", $time,
                     doneCount - doneBefore);
        end
    endtask

    task automatic readBurst(input requestCode target, input logic [dataWidth-1:0] base);
        int cycles;
        logic [dataWidth-1:0] expected;
        readWords.delete();
        readStamps.delete();
        issueRequest(1'b0, target);
        cycles = 0;
        while (readWords.size() < burstLength && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        waitCycles(4);
        if (readWords.size() != burstLength) begin
            errorCount++;
            $display("Read burst at %0t returned %0d words instead of %0d", $time,
                     readWords.size(), burstLength);
        end
        for (int i = 0; i < readWords.size() && i < burstLength; i++) begin
            expected = base + dataWidth'(i);
            if (readWords[i] !== expected) begin
                errorCount++;
                $display("Mismatch at %0t: readData word %0d got %h expected %h",
                         readStamps[i], i, readWords[i], expected);
            end
            // Words of one burst arrive on consecutive cycles
            if (i > 0) begin
                if (readStamps[i] - readStamps[i-1] != wordSpacing) begin
                    errorCount++;
                    $display("Read burst at %0t had a gap before word %0d",
                             readStamps[i], i);
                end
            end
        end
    endtask

    // Nothing may move while requests are gated or illegal
    task automatic quietWindow(input logic enaLevel, input requestCode loadCode,
                               input requestCode readCode, input string label);
        int cycles;
        int doneBefore;
        logic stateMoved;
        logic [3:0] stateBefore;
        @(negedge clk);
        doneBefore = doneCount;
        stateBefore = memoryState;
        stateMoved = 1'b0;
        readWords.delete();
        readStamps.delete();
        @(posedge clk);
        ena       <= enaLevel;
        loadState <= loadCode;
        readState <= readCode;
        // Offered words would complete a load if the request were taken
        loadValid <= 1'b1;
        cycles = 0;
        while (cycles < quietCycles) begin
            @(negedge clk);
            if (memoryState !== stateBefore && !stateMoved) begin
                stateMoved = 1'b1;
                errorCount++;
                $display("Mismatch at %0t: memoryState got %b expected %b during %s",
                         $time, memoryState, stateBefore, label);
            end
            cycles++;
        end
        @(posedge clk);
        ena       <= 1'b1;
        loadState <= reqIdle;
        readState <= reqIdle;
        loadValid <= 1'b0;
        waitCycles(2);
        @(negedge clk);
        if (doneCount != doneBefore) begin
            errorCount++;
            $display("loadDone appeared at %0t during %s", $time, label);
        end
        if (readWords.size() != 0) begin
            errorCount++;
            $display("readValid appeared at %0t during %s", $time, label);
        end
        if (!stateMoved && memoryState !== stateBefore) begin
            errorCount++;
            $display("Mismatch at %0t: memoryState got %b expected %b", $time,
                     memoryState, stateBefore);
        end
    endtask

    task automatic quietChecks();
        quietWindow(1'b0, reqBias, reqIdle, "ena low with a load request");
        quietWindow(1'b0, reqIdle, reqLayer, "ena low with a read request");
        quietWindow(1'b1, requestCode'(3'b011), reqIdle, "illegal load code");
        quietWindow(1'b1, reqIdle, requestCode'(3'b111), "illegal read code");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int fileHandle;
        int fieldCount;
        int commandCount;
        string lineText;
        string opText;
        string targetText;
        logic [dataWidth-1:0] baseValue;
        logic [3:0] expectState;
        requestCode target;
        reset        = 1'b1;
        ena          = 1'b0;
        loadState    = reqIdle;
        readState    = reqIdle;
        loadData     = '0;
        loadValid    = 1'b0;
        errorCount   = 0;
        doneCount    = 0;
        commandCount = 0;
        lfsrState    = 32'hfc6a5037;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        ena   <= 1'b1;
        @(negedge clk);
        if (memoryState !== 4'b0101) begin
            errorCount++;
            $display("Mismatch at %0t: memoryState got %b expected 0101", $time,
                     memoryState);
        end
        if (loadDone !== 1'b0) begin
            errorCount++;
            $display("Mismatch at %0t: loadDone got %b expected 0", $time, loadDone);
        end
        if (readValid !== 1'b0) begin
            errorCount++;
            $display("Mismatch at %0t: readValid got %b expected 0", $time, readValid);
        end
        quietChecks();
        fileHandle = $fopen("testbench/memoryStimulus.txt", "r");
        if (fileHandle == 0) begin
            errorCount++;
            $display("Could not open the stimulus file");
        end else begin
            while (!$feof(fileHandle)) begin
                lineText = "";
                void'($fgets(lineText, fileHandle));
                if (lineText.len() == 0 || lineText[0] == "#") begin
                    continue;
                end
                fieldCount = $sscanf(lineText, "%s %s %h %b", opText, targetText,
                                     baseValue, expectState);
                if (fieldCount < 1) begin
                    continue;
                end
                target = targetCode(targetText);
                commandCount++;
                if (fieldCount != 4 || target == reqIdle) begin
                    errorCount++;
                    $display("Malformed stimulus line: %s", lineText);
                    continue;
                end
                if (opText == "load") begin
                    loadBurst(target, baseValue);
                end else if (opText == "read") begin
                    readBurst(target, baseValue);
                end else begin
                    errorCount++;
                    $display("Unknown operation in stimulus line: %s", lineText);
                end
                @(negedge clk);
                if (memoryState !== expectState) begin
                    errorCount++;
                    $display("Mismatch at %0t: memoryState got %b expected %b", $time,
                             memoryState, expectState);
                end
            end
            $fclose(fileHandle);
        end
        quietChecks();
        $display("Finished %0d commands with %0d errors", commandCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/memoryStimulus.txt ====
# operation target base expectedMemoryState, base and words are hex
# memoryState bits are biasFull biasEmpty weightFull weightEmpty
load   bias   10000000 1001
load   weight 20000000 1010
read   bias   10000000 0110
read   weight 20000000 0101
# Layer traffic leaves the FIFO flags alone
load   layer  30000000 0101
read   layer  30000000 0101
load   bias   40000000 1001
load   weight 50000000 1010
load   layer  60000000 1010
read   layer  60000000 1010
# Reload over stale bias words
load   bias   7000abcd 1010
read   bias   7000abcd 0110
read   weight 50000000 0101
read   layer  60000000 0101
load   weight a5a50000 0110
load   weight 0badf000 0110
read   weight 0badf000 0101
# Word values wrap past the top of the range
load   bias   fffffff8 1001
read   bias   fffffff8 0101
load   layer  12345678 0101
load   layer  87654321 0101
read   layer  87654321 0101
load   weight deadbe00 0110
load   bias   00c0ffee 1010
read   weight deadbe00 1001
read   bias   00c0ffee 0101

// ==== all.f ====
source/memoryPkg.sv
source/paramFifo.sv
source/layerBuffer.sv
source/wordCounter.sv
source/memoryController.sv
source/memorySubsystem.sv
testbench/memorySubsystemTb.sv
